// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [3:0]           byte_en_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  // operand source for the execute stage
  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
  localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 of the supported loads and stores
  localparam logic [2:0] F3_BYTE   = 3'b000;
  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_BYTE_U = 3'b100;

  localparam addr_t RESET_PC = 32'h0000_0000;
  // addi x0, x0, 0
  localparam xlen_t NOP_WORD = 32'h0000_0013;

endpackage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
  ( input  logic                clk
  , input  logic                reset
  , input  logic                stall
  , input  logic                branch_taken
  , input  rv_core_pkg::addr_t  branch_target
  , output rv_core_pkg::addr_t  pc
  );

  rv_core_pkg::addr_t pc_next;

  // a taken branch wins over a stall, the two never overlap anyway
  always_comb begin
    if (branch_taken) begin
      pc_next = branch_target;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_core_pkg::RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  ( input  logic                  clk
  , input  rv_core_pkg::xlen_t    instr
  , input  rv_core_pkg::reg_idx_t wb_rd
  , input  rv_core_pkg::xlen_t    wb_data
  , input  logic                  wb_we
  , output rv_core_pkg::reg_idx_t rs1
  , output rv_core_pkg::reg_idx_t rs2
  , output rv_core_pkg::reg_idx_t rd
  , output rv_core_pkg::xlen_t    rs1_val
  , output rv_core_pkg::xlen_t    rs2_val
  , output rv_core_pkg::xlen_t    imm
  , output rv_core_pkg::alu_op_t  alu_op
  , output logic                  alu_src_imm
  , output logic                  reg_write
  , output logic                  mem_read
  , output logic                  mem_write
  , output logic                  is_branch
  , output logic [2:0]            funct3
  );

  rv_core_pkg::xlen_t regs [32];
  logic [6:0]         opcode;

  function automatic rv_core_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3,
                                                           input logic       sub);
    case (f3)
      3'b000:  return sub ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b010:  return rv_core_pkg::ALU_SLT;
      3'b100:  return rv_core_pkg::ALU_XOR;
      3'b110:  return rv_core_pkg::ALU_OR;
      3'b111:  return rv_core_pkg::ALU_AND;
      default: return rv_core_pkg::ALU_ADD;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];

  always_comb begin
    alu_op      = rv_core_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    is_branch   = 1'b0;
    imm         = {{20{instr[31]}}, instr[31:20]};
    case (opcode)
      rv_core_pkg::OPC_RTYPE: begin
        // bit 30 separates sub from add
        alu_op    = alu_from_funct3(funct3, instr[30]);
        reg_write = 1'b1;
      end
      rv_core_pkg::OPC_ITYPE: begin
        alu_op      = alu_from_funct3(funct3, 1'b0);
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      rv_core_pkg::OPC_LOAD: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        mem_read    = 1'b1;
      end
      rv_core_pkg::OPC_STORE: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
        imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      rv_core_pkg::OPC_BRANCH: begin
        is_branch = 1'b1;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      default: begin
      end
    endcase
  end

  // register file, written by writeback and bypassed on a same-cycle read
  always_ff @(posedge clk) begin
    if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  ( input  rv_core_pkg::xlen_t    rs1_val
  , input  rv_core_pkg::xlen_t    rs2_val
  , input  rv_core_pkg::xlen_t    imm
  , input  rv_core_pkg::xlen_t    mem_fwd
  , input  rv_core_pkg::xlen_t    wb_fwd
  , input  rv_core_pkg::addr_t    pc
  , input  rv_core_pkg::fwd_sel_t fwd_a
  , input  rv_core_pkg::fwd_sel_t fwd_b
  , input  rv_core_pkg::alu_op_t  alu_op
  , input  logic                  alu_src_imm
  , input  logic                  is_branch
  , output rv_core_pkg::xlen_t    alu_result
  , output rv_core_pkg::xlen_t    store_data
  , output logic                  branch_taken
  , output rv_core_pkg::addr_t    branch_target
  );

  rv_core_pkg::xlen_t op_a;
  rv_core_pkg::xlen_t op_b_reg;
  rv_core_pkg::xlen_t op_b;

  function automatic rv_core_pkg::xlen_t pick(input rv_core_pkg::fwd_sel_t sel,
                                              input rv_core_pkg::xlen_t    reg_val,
                                              input rv_core_pkg::xlen_t    mem_val,
                                              input rv_core_pkg::xlen_t    wb_val);
    case (sel)
      rv_core_pkg::FWD_MEM: return mem_val;
      rv_core_pkg::FWD_WB:  return wb_val;
      default:              return reg_val;
    endcase
  endfunction

  assign op_a     = pick(fwd_a, rs1_val, mem_fwd, wb_fwd);
  assign op_b_reg = pick(fwd_b, rs2_val, mem_fwd, wb_fwd);
  assign op_b     = alu_src_imm ? imm : op_b_reg;

  // stores take the forwarded rs2, not the immediate
  assign store_data = op_b_reg;

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_SUB: alu_result = op_a - op_b;
      rv_core_pkg::ALU_AND: alu_result = op_a & op_b;
      rv_core_pkg::ALU_OR:  alu_result = op_a | op_b;
      rv_core_pkg::ALU_XOR: alu_result = op_a ^ op_b;
      rv_core_pkg::ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      default:              alu_result = op_a + op_b;
    endcase
  end

  // beq only
  assign branch_taken  = is_branch && (op_a == op_b_reg);
  assign branch_target = pc + imm;

endmodule

// File: hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
  ( input  rv_core_pkg::xlen_t     alu_result
  , input  rv_core_pkg::xlen_t     store_data
  , input  logic [2:0]             funct3
  , input  logic                   mem_read
  , input  logic                   mem_write
  , input  rv_core_pkg::xlen_t     data_rdata
  , output rv_core_pkg::addr_t     data_addr
  , output rv_core_pkg::xlen_t     data_wdata
  , output rv_core_pkg::byte_en_t  data_we
  , output rv_core_pkg::xlen_t     load_data
  );

  logic [1:0] lane;
  logic [7:0] load_byte;

  assign lane      = alu_result[1:0];
  assign data_addr = alu_result;

  // sb puts the byte on every lane, the enable picks one
  assign data_wdata = (funct3 == rv_core_pkg::F3_WORD) ? store_data : {4{store_data[7:0]}};

  always_comb begin
    if (!mem_write) begin
      data_we = 4'b0000;
    end else if (funct3 == rv_core_pkg::F3_WORD) begin
      data_we = 4'b1111;
    end else begin
      data_we = 4'b0001 << lane;
    end
  end

  assign load_byte = data_rdata[{lane, 3'b000} +: 8];

  always_comb begin
    if (!mem_read) begin
      load_data = '0;
    end else begin
      case (funct3)
        rv_core_pkg::F3_BYTE:   load_data = {{24{load_byte[7]}}, load_byte};
        rv_core_pkg::F3_BYTE_U: load_data = {24'b0, load_byte};
        default:                load_data = data_rdata;
      endcase
    end
  end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
  ( input  rv_core_pkg::reg_idx_t rs1e
  , input  rv_core_pkg::reg_idx_t rs2e
  , input  rv_core_pkg::reg_idx_t rde
  , input  rv_core_pkg::reg_idx_t rdm
  , input  rv_core_pkg::reg_idx_t rdw
  , input  rv_core_pkg::reg_idx_t rs1d
  , input  rv_core_pkg::reg_idx_t rs2d
  , input  logic                  reg_write_m
  , input  logic                  reg_write_w
  , input  logic                  mem_read_e
  , input  logic                  branch_taken
  , output rv_core_pkg::fwd_sel_t fwd_a
  , output rv_core_pkg::fwd_sel_t fwd_b
  , output logic                  stall_f
  , output logic                  stall_d
  , output logic                  flush_d
  , output logic                  flush_e
  );

  logic load_use;

  // youngest producer first, x0 is never forwarded
  function automatic rv_core_pkg::fwd_sel_t fwd_for(input rv_core_pkg::reg_idx_t src);
    if (src == '0) begin
      return rv_core_pkg::FWD_REG;
    end else if (reg_write_m && rdm == src) begin
      return rv_core_pkg::FWD_MEM;
    end else if (reg_write_w && rdw == src) begin
      return rv_core_pkg::FWD_WB;
    end
    return rv_core_pkg::FWD_REG;
  endfunction

  always_comb begin
    fwd_a = fwd_for(rs1e);
    fwd_b = fwd_for(rs2e);
  end

  // load result is not ready until writeback, so hold decode one cycle
  assign load_use = mem_read_e && (rde != '0) && (rde == rs1d || rde == rs2d);

  assign stall_f = load_use;
  assign stall_d = load_use;
  assign flush_d = branch_taken;
  assign flush_e = branch_taken;

endmodule

// File: hdl/rv_core_pipelined.sv
`timescale 1ns/1ps

// five-stage core, the stage registers live here
module rv_core_pipelined
  ( input  logic                  clk
  , input  logic                  reset

  , output rv_core_pkg::addr_t    instr_addr
  , input  rv_core_pkg::xlen_t    instr_rdata

  , output rv_core_pkg::addr_t    data_addr
  , output rv_core_pkg::xlen_t    data_wdata
  , output rv_core_pkg::byte_en_t data_we
  , input  rv_core_pkg::xlen_t    data_rdata
  );

  rv_core_pkg::addr_t    pc_f, pc_d, pc_e;
  rv_core_pkg::xlen_t    instr_d;

  rv_core_pkg::reg_idx_t rs1_d, rs2_d, rd_d, rs1_e, rs2_e, rd_e, rd_m, rd_w;
  rv_core_pkg::xlen_t    rs1_val_d, rs2_val_d, imm_d, rs1_val_e, rs2_val_e, imm_e;
  rv_core_pkg::alu_op_t  alu_op_d, alu_op_e;
  logic                  alu_src_imm_d, alu_src_imm_e;
  logic                  reg_write_d, reg_write_e, reg_write_m, reg_write_w;
  logic                  mem_read_d, mem_read_e, mem_read_m, mem_read_w;
  logic                  mem_write_d, mem_write_e, mem_write_m;
  logic                  is_branch_d, is_branch_e;
  logic [2:0]            funct3_d, funct3_e, funct3_m;

  rv_core_pkg::xlen_t    alu_result_e, store_data_e, alu_result_m, store_data_m;
  rv_core_pkg::xlen_t    load_data_m, alu_result_w, load_data_w, wb_data;
  logic                  branch_taken;
  rv_core_pkg::addr_t    branch_target;

  rv_core_pkg::fwd_sel_t fwd_a, fwd_b;
  logic                  stall_f, stall_d, flush_d, flush_e;

  fetch_stage u_fetch_stage
    ( .clk           ( clk           )
    , .reset         ( reset         )
    , .stall         ( stall_f       )
    , .branch_taken  ( branch_taken  )
    , .branch_target ( branch_target )
    , .pc            ( pc_f          )
    );

  assign instr_addr = pc_f;

  // if/id, a flushed slot becomes a nop
  always_ff @(posedge clk) begin
    if (reset || flush_d) begin
      instr_d <= rv_core_pkg::NOP_WORD;
    end else if (!stall_d) begin
      instr_d <= instr_rdata;
    end
    if (!stall_d) begin
      pc_d <= pc_f;
    end
  end

  decode_stage u_decode_stage
    ( .clk         ( clk           )
    , .instr       ( instr_d       )
    , .wb_rd       ( rd_w          )
    , .wb_data     ( wb_data       )
    , .wb_we       ( reg_write_w   )
    , .rs1         ( rs1_d         )
    , .rs2         ( rs2_d         )
    , .rd          ( rd_d          )
    , .rs1_val     ( rs1_val_d     )
    , .rs2_val     ( rs2_val_d     )
    , .imm         ( imm_d         )
    , .alu_op      ( alu_op_d      )
    , .alu_src_imm ( alu_src_imm_d )
    , .reg_write   ( reg_write_d   )
    , .mem_read    ( mem_read_d    )
    , .mem_write   ( mem_write_d   )
    , .is_branch   ( is_branch_d   )
    , .funct3      ( funct3_d      )
    );

  // id/ex, a stalled decode also sends a bubble into execute
  always_ff @(posedge clk) begin
    if (reset || flush_e || stall_d) begin
      reg_write_e <= 1'b0;
      mem_read_e  <= 1'b0;
      mem_write_e <= 1'b0;
      is_branch_e <= 1'b0;
    end else begin
      reg_write_e <= reg_write_d;
      mem_read_e  <= mem_read_d;
      mem_write_e <= mem_write_d;
      is_branch_e <= is_branch_d;
    end
  end

  always_ff @(posedge clk) begin
    pc_e          <= pc_d;
    rs1_e         <= rs1_d;
    rs2_e         <= rs2_d;
    rd_e          <= rd_d;
    rs1_val_e     <= rs1_val_d;
    rs2_val_e     <= rs2_val_d;
    imm_e         <= imm_d;
    alu_op_e      <= alu_op_d;
    alu_src_imm_e <= alu_src_imm_d;
    funct3_e      <= funct3_d;
  end

  execute_stage u_execute_stage
    ( .rs1_val       ( rs1_val_e     )
    , .rs2_val       ( rs2_val_e     )
    , .imm           ( imm_e         )
    , .mem_fwd       ( alu_result_m  )
    , .wb_fwd        ( wb_data       )
    , .pc            ( pc_e          )
    , .fwd_a         ( fwd_a         )
    , .fwd_b         ( fwd_b         )
    , .alu_op        ( alu_op_e      )
    , .alu_src_imm   ( alu_src_imm_e )
    , .is_branch     ( is_branch_e   )
    , .alu_result    ( alu_result_e  )
    , .store_data    ( store_data_e  )
    , .branch_taken  ( branch_taken  )
    , .branch_target ( branch_target )
    );

  // ex/mem
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_write_m <= 1'b0;
      mem_read_m  <= 1'b0;
      mem_write_m <= 1'b0;
    end else begin
      reg_write_m <= reg_write_e;
      mem_read_m  <= mem_read_e;
      mem_write_m <= mem_write_e;
    end
    alu_result_m <= alu_result_e;
    store_data_m <= store_data_e;
    rd_m         <= rd_e;
    funct3_m     <= funct3_e;
  end

  memory_stage u_memory_stage
    ( .alu_result ( alu_result_m )
    , .store_data ( store_data_m )
    , .funct3     ( funct3_m     )
    , .mem_read   ( mem_read_m   )
    , .mem_write  ( mem_write_m  )
    , .data_rdata ( data_rdata   )
    , .data_addr  ( data_addr    )
    , .data_wdata ( data_wdata   )
    , .data_we    ( data_we      )
    , .load_data  ( load_data_m  )
    );

  // mem/wb
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_write_w <= 1'b0;
      mem_read_w  <= 1'b0;
    end else begin
      reg_write_w <= reg_write_m;
      mem_read_w  <= mem_read_m;
    end
    alu_result_w <= alu_result_m;
    load_data_w  <= load_data_m;
    rd_w         <= rd_m;
  end

  assign wb_data = mem_read_w ? load_data_w : alu_result_w;

  hazard_unit u_hazard_unit
    ( .rs1e         ( rs1_e        )
    , .rs2e         ( rs2_e        )
    , .rde          ( rd_e         )
    , .rdm          ( rd_m         )
    , .rdw          ( rd_w         )
    , .rs1d         ( rs1_d        )
    , .rs2d         ( rs2_d        )
    , .reg_write_m  ( reg_write_m  )
    , .reg_write_w  ( reg_write_w  )
    , .mem_read_e   ( mem_read_e   )
    , .branch_taken ( branch_taken )
    , .fwd_a        ( fwd_a        )
    , .fwd_b        ( fwd_b        )
    , .stall_f      ( stall_f      )
    , .stall_d      ( stall_d      )
    , .flush_d      ( flush_d      )
    , .flush_e      ( flush_e      )
    );

endmodule

// File: verification/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties
  ( input  logic                  clk
  , input  logic                  reset
  , input  rv_core_pkg::byte_en_t data_we
  , input  logic                  stall_d
  , input  logic                  flush_e
  );

  int unsigned failures = 0;
  logic [2:0]  quiet_left;

  // counts down the edges after reset where no store may appear
  always_ff @(posedge clk) begin
    if (reset) begin
      quiet_left <= 3'd4;
    end else if (quiet_left != 3'd0) begin
      quiet_left <= quiet_left - 3'd1;
    end
  end

  no_store_near_reset: assert property (@(posedge clk) quiet_left != 3'd0 |-> data_we == 4'b0000)
    else begin
      $error("store while reset is held or within four cycles after it");
      failures++;
    end

  no_stall_with_flush: assert property (@(posedge clk) disable iff (reset) !(flush_e && stall_d))
    else begin
      $error("flush_e and stall_d set together");
      failures++;
    end

  // a load-use bubble never needs a second cycle
  single_cycle_stall: assert property (@(posedge clk) disable iff (reset) stall_d |=> !stall_d)
    else begin
      $error("stall_d held for more than one cycle");
      failures++;
    end

endmodule

bind rv_core_pipelined rv_core_properties u_rv_core_properties
  ( .clk     ( clk     )
  , .reset   ( reset   )
  , .data_we ( data_we )
  , .stall_d ( stall_d )
  , .flush_e ( flush_e )
  );

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int    MEM_WORDS = 256;
  localparam string TESTDATA  = "verification/rv_core_testdata.hex";

  logic                  clk;
  logic                  reset;
  rv_core_pkg::addr_t    instr_addr;
  rv_core_pkg::xlen_t    instr_rdata;
  rv_core_pkg::addr_t    data_addr;
  rv_core_pkg::xlen_t    data_wdata;
  rv_core_pkg::byte_en_t data_we;
  rv_core_pkg::xlen_t    data_rdata;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];

  // expected stores in program order
  logic [31:0] exp_addr [$];
  logic [3:0]  exp_we [$];
  logic [31:0] exp_data [$];

  int n_prog         = 0;
  int n_expected     = 0;
  int stores_seen    = 0;
  int timeout_cycles = 0;
  bit loaded         = 1'b0;

  rv_core_pipelined dut
    ( .clk         ( clk         )
    , .reset       ( reset       )
    , .instr_addr  ( instr_addr  )
    , .instr_rdata ( instr_rdata )
    , .data_addr   ( data_addr   )
    , .data_wdata  ( data_wdata  )
    , .data_we     ( data_we     )
    , .data_rdata  ( data_rdata  )
    );

  always #20 clk = ~clk;

  // both memories are word addressed and read combinationally
  assign instr_rdata = imem[instr_addr[9:2]];
  assign data_rdata  = dmem[data_addr[9:2]];

  function automatic logic [31:0] byte_mask(input logic [3:0] we);
    return {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t ns: store %0d %s is %h, expected %h",
               $time, stores_seen, what, got, expected);
      $display("STATUS: FAIL");
      $fatal(1, "store mismatch");
    end
  endtask

  task automatic check_store();
    logic [31:0] mask;
    if (stores_seen >= n_expected) begin
      $display("unexpected store of %h to address %h after the last expected store",
               data_wdata, data_addr);
      $display("STATUS: FAIL");
      $fatal(1, "extra store");
    end else begin
      mask = byte_mask(exp_we[stores_seen]);
      check_value("address", data_addr, exp_addr[stores_seen]);
      check_value("byte enable", {28'b0, data_we}, {28'b0, exp_we[stores_seen]});
      check_value("data", data_wdata & mask, exp_data[stores_seen] & mask);
      stores_seen++;
    end
  endtask

  // P lines hold program words and S lines the expected stores
  task automatic read_program_and_stores();
    int          fd;
    int          code;
    string       line;
    logic [31:0] word;
    logic [31:0] addr;
    logic [3:0]  we;
    logic [31:0] data;
    fd = $fopen(TESTDATA, "r");
    if (fd == 0) begin
      $display("could not open the test data file %s", TESTDATA);
      $display("STATUS: FAIL");
      $fatal(1, "missing test data");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] == "P") begin
          code = $sscanf(line, "P %h", word);
          if (code != 1) begin
            $display("malformed program line in the test data file: %s", line);
            $display("STATUS: FAIL");
            $fatal(1, "bad test data");
          end else begin
            imem[n_prog[7:0]] = word;
            n_prog++;
          end
        end else if (line.len() > 0 && line[0] == "S") begin
          code = $sscanf(line, "S %h %h %h", addr, we, data);
          if (code != 3) begin
            $display("malformed store line in the test data file: %s", line);
            $display("STATUS: FAIL");
            $fatal(1, "bad test data");
          end else begin
            exp_addr.push_back(addr);
            exp_we.push_back(we);
            exp_data.push_back(data);
          end
        end
      end
      $fclose(fd);
      n_expected = exp_addr.size();
    end
  endtask

  // data memory write and store check share the edge
  always @(posedge clk) begin
    if (data_we != 4'b0000) begin
      check_store();
      dmem[data_addr[9:2]] <= (dmem[data_addr[9:2]] & ~byte_mask(data_we))
                              | (data_wdata & byte_mask(data_we));
    end
  end

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    void'($urandom(32'h88d0));
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i[7:0]] = rv_core_pkg::NOP_WORD;
      dmem[i[7:0]] = $urandom();
    end
    read_program_and_stores();
    timeout_cycles = 40 * n_prog + 100;
    loaded = 1'b1;

    repeat (16) @(posedge clk);
    #2 reset = 1'b0;

    wait (stores_seen == n_expected);
    // room for a store that should have been skipped
    repeat (20) @(posedge clk);

    if (dut.u_rv_core_properties.failures == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("%0d bound assertion failures", dut.u_rv_core_properties.failures);
      $display("STATUS: FAIL");
      $fatal(1, "run ended with errors");
    end
  end

  initial begin
    wait (loaded);
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: the expected stores did not all arrive within %0d cycles",
             timeout_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: verification/rv_core_testdata.hex
# P <instruction word>
# S <address> <byte enable> <data, compared under the enable>
P 10000513
P 00D00093
P FFA00113
P 002081B3
P 00352023
P 40208233
P 00452223
P 0020F2B3
P 0020E333
P 0020C3B3
P 00112433
P 00552423
P 00652623
P 00752823
P 00852A23
P 0020A4B3
P 00952C23
P 00052583
P 00158633
P 00C52E23
P 00108663
P 02152023
P 02252223
P 02152423
P 00208663
P 02252623
P 02352823
P F8000713
P 02052A23
P 02E50AA3
P 03452783
P 02F52C23
P 03550803
P 03554883
P 03052E23
P 05152023
# add, sub, and, or, xor, slt true, slt false
S 00000100 F 00000007
S 00000104 F 00000013
S 00000108 F 00000008
S 0000010C F FFFFFFFF
S 00000110 F FFFFFFF7
S 00000114 F 00000001
S 00000118 F 00000000
# load then dependent add
S 0000011C F 00000014
# taken beq skips 0x120 and 0x124
S 00000128 F 0000000D
S 0000012C F FFFFFFFA
S 00000130 F 00000007
# sb lane 1, then lw, lb and lbu of it
S 00000134 F 00000000
S 00000135 2 00008000
S 00000138 F 00008000
S 0000013C F FFFFFF80
S 00000140 F 00000080

// File: rv_core_pipelined.f
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/rv_core_pipelined.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

// File: Makefile
# Verilator build and run of the pipelined core testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f rv_core_pipelined.f \
		--top-module rv_core_tb -o rv_core_sim

run: build
	./obj_dir/rv_core_sim +verilator+error+limit+100 | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

lint:
	verilator --lint-only --timing --assert -f rv_core_pipelined.f \
		--top-module rv_core_tb

clean:
	rm -rf obj_dir sim.log
